// ==== flist.f ====
+incdir+verilog
+incdir+tb
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_stage.sv
verilog/div_unit.sv
verilog/hilo_unit.sv
verilog/ex_top.sv
tb/tb_ex_top.sv

// ==== tb/tb_ex_checks.svh ====
`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

// length of the leading run of v from bit 31 down
function automatic int lead_run(input logic [31:0] w, input logic v);
    int n;
    n = 0;
    while (n < 32 && w[31 - n] == v) begin
        n++;
    end
    return n;
endfunction

// signed overflow from a 33-bit sum for add and sub only
function automatic logic model_ovf(input ex_pkg::ex_req_t r);
    logic [32:0] s;
    s = '0;
    case (r.aluop)
        ex_pkg::op_add: s = {r.op1[31], r.op1} + {r.op2[31], r.op2};
        ex_pkg::op_sub: s = {r.op1[31], r.op1} - {r.op2[31], r.op2};
        default: ;
    endcase
    return s[32] ^ s[31];
endfunction

function automatic logic [31:0] model_res(input ex_pkg::ex_req_t r,
                                          input logic [31:0] h,
                                          input logic [31:0] l);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] ext;
    a   = r.op1;
    b   = r.op2;
    ext = {{32{a[31]}}, a};                     // sign copies feed sra
    case (r.aluop)
        ex_pkg::op_or:       return a | b;
        ex_pkg::op_and:      return a & b;
        ex_pkg::op_xor:      return a ^ b;
        ex_pkg::op_nor:      return ~(a | b);
        ex_pkg::op_sll:      return a << b[4:0];
        ex_pkg::op_srl:      return a >> b[4:0];
        ex_pkg::op_sra:      return 32'(ext >> b[4:0]);
        ex_pkg::op_movn,
        ex_pkg::op_movz:     return a;
        ex_pkg::op_mfhi:     return h;
        ex_pkg::op_mflo:     return l;
        ex_pkg::op_add,
        ex_pkg::op_addu:     return a + b;
        ex_pkg::op_sub,
        ex_pkg::op_subu:     return a - b;
        ex_pkg::op_slt:      return 32'((a[31] != b[31]) ? a[31] : (a < b));
        ex_pkg::op_sltu:     return 32'(a < b);
        ex_pkg::op_mul:      return a * b;
        ex_pkg::op_clz:      return 32'(lead_run(a, 1'b0));
        ex_pkg::op_clo:      return 32'(lead_run(a, 1'b1));
        ex_pkg::op_jal_link: return r.link_addr;
        default:             return '0;
    endcase
endfunction

// 64-bit product as the low 64 bits of the extended operands
function automatic logic [63:0] full_prod(input logic sgn,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] xa;
    logic [63:0] xb;
    xa = sgn ? {{32{a[31]}}, a} : {32'b0, a};
    xb = sgn ? {{32{b[31]}}, b} : {32'b0, b};
    return xa * xb;
endfunction

// {remainder, quotient} truncating toward zero
function automatic logic [63:0] model_div(input logic sgn,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    longint sa;
    longint sb;
    longint q;
    longint rm;
    if (b == '0) begin
        return '0;
    end
    sa = sgn ? longint'($signed(a)) : longint'(a);
    sb = sgn ? longint'($signed(b)) : longint'(b);
    q  = sa / sb;
    rm = sa % sb;
    return {rm[31:0], q[31:0]};
endfunction

// shadow HI/LO after the commit edge of r
task automatic apply_hilo(input ex_pkg::ex_req_t r);
    case (r.aluop)
        ex_pkg::op_mthi: sh_hi = r.op1;
        ex_pkg::op_mtlo: sh_lo = r.op1;
        ex_pkg::op_mult,
        ex_pkg::op_multu:
            {sh_hi, sh_lo} = full_prod(r.aluop == ex_pkg::op_mult, r.op1, r.op2);
        ex_pkg::op_madd,
        ex_pkg::op_maddu:
            {sh_hi, sh_lo} = {sh_hi, sh_lo} +
                             full_prod(r.aluop == ex_pkg::op_madd, r.op1, r.op2);
        ex_pkg::op_msub,
        ex_pkg::op_msubu:
            {sh_hi, sh_lo} = {sh_hi, sh_lo} -
                             full_prod(r.aluop == ex_pkg::op_msub, r.op1, r.op2);
        ex_pkg::op_div,
        ex_pkg::op_divu:
            {sh_hi, sh_lo} = model_div(r.aluop == ex_pkg::op_div, r.op1, r.op2);
        default: ;
    endcase
endtask

// outputs settle well before the falling edge
a_stall: assert property (@(negedge clk) stall == (stall_left != 0))
    else fail_now($sformatf("** Error at %0t: stall_o expected %0b got %0b",
                            $time, stall_left != 0, stall));

a_res: assert property (@(negedge clk) disable iff (!rst_n)
    wb.res == model_res(ex_req, sh_hi, sh_lo))
    else fail_now($sformatf("** Error at %0t: wb_o.res expected %h got %h",
                            $time, model_res(ex_req, sh_hi, sh_lo), wb.res));

a_waddr: assert property (@(negedge clk) disable iff (!rst_n) wb.waddr == ex_req.waddr)
    else fail_now($sformatf("** Error at %0t: wb_o.waddr expected %h got %h",
                            $time, ex_req.waddr, wb.waddr));

a_reg_we: assert property (@(negedge clk) disable iff (!rst_n)
    wb.reg_we == (ex_req.reg_we && !model_ovf(ex_req)))
    else fail_now($sformatf("** Error at %0t: wb_o.reg_we expected %0b got %0b",
                            $time, ex_req.reg_we && !model_ovf(ex_req), wb.reg_we));

a_mem_addr: assert property (@(negedge clk) disable iff (!rst_n)
    mem.addr == ex_req.op1 + ex_req.op2)
    else fail_now($sformatf("** Error at %0t: mem_o.addr expected %h got %h",
                            $time, ex_req.op1 + ex_req.op2, mem.addr));

a_mem_wdata: assert property (@(negedge clk) disable iff (!rst_n) mem.wdata == ex_req.reg2)
    else fail_now($sformatf("** Error at %0t: mem_o.wdata expected %h got %h",
                            $time, ex_req.reg2, mem.wdata));

a_mem_op: assert property (@(negedge clk) disable iff (!rst_n) mem.aluop == ex_req.aluop)
    else fail_now($sformatf("** Error at %0t: mem_o.aluop expected %h got %h",
                            $time, ex_req.aluop, mem.aluop));

`endif

// ==== tb/tb_ex_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module tb_ex_top;

    // about 200 single-cycle ops plus 10 divides of up to 34 cycles with ample margin
    localparam int MAX_CYCLES = 2000;
    localparam int DIV_STALL  = `EX_DIV_STEPS + 1;

    logic                    clk;
    logic                    rst_n;
    ex_pkg::ex_req_t         ex_req;
    ex_pkg::wb_req_t         wb;
    ex_pkg::mem_req_t        mem;
    logic                    stall;
    logic [`EX_WORD_W-1:0]   sh_hi;
    logic [`EX_WORD_W-1:0]   sh_lo;
    int                      stall_left;                // stall cycles still expected
    int                      cycles;

    ex_top dut0 (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .ex_req_i (ex_req),
        .wb_o     (wb),
        .mem_o    (mem),
        .stall_o  (stall)
    );

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    `include "tb_ex_checks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_now($sformatf("timeout: run still going after %0d cycles", cycles));
        end
    end

    // edge values five times in eight and a random word otherwise
    function automatic logic [31:0] pick_val();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    // decode side of the result group
    function automatic ex_pkg::alu_sel_e sel_of(input ex_pkg::alu_op_e op);
        case (op)
            ex_pkg::op_or, ex_pkg::op_and, ex_pkg::op_xor, ex_pkg::op_nor:
                return ex_pkg::sel_logic;
            ex_pkg::op_sll, ex_pkg::op_srl, ex_pkg::op_sra:
                return ex_pkg::sel_shift;
            ex_pkg::op_movn, ex_pkg::op_movz, ex_pkg::op_mfhi, ex_pkg::op_mflo:
                return ex_pkg::sel_move;
            ex_pkg::op_add, ex_pkg::op_addu, ex_pkg::op_sub, ex_pkg::op_subu,
            ex_pkg::op_slt, ex_pkg::op_sltu, ex_pkg::op_mul, ex_pkg::op_clz,
            ex_pkg::op_clo:
                return ex_pkg::sel_arith;
            ex_pkg::op_jal_link:
                return ex_pkg::sel_link;
            default:
                return ex_pkg::sel_nop;
        endcase
    endfunction

    function automatic ex_pkg::ex_req_t make_req(input ex_pkg::alu_op_e op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        ex_pkg::ex_req_t r;
        r.aluop     = op;
        r.alusel    = sel_of(op);
        r.op1       = a;
        r.op2       = b;
        r.reg2      = $urandom;
        r.waddr     = `EX_REG_ADDR_W'($urandom);
        r.reg_we    = 1'b1;
        r.link_addr = $urandom;
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        if (stall_left > 0) begin
            stall_left--;
        end
        #10;                                            // drive point
    endtask

    // hold r until stall_o drops and pass its commit edge
    task automatic issue(input ex_pkg::ex_req_t r, input int n_stall);
        ex_req     = r;
        stall_left = n_stall;
        #1;
        while (stall) begin
            step();
        end
        step();
        apply_hilo(r);
    endtask

    task automatic read_hilo();
        issue(make_req(ex_pkg::op_mfhi, $urandom, $urandom), 0);
        issue(make_req(ex_pkg::op_mflo, $urandom, $urandom), 0);
    endtask

    task automatic run_single_cycle();
        ex_pkg::alu_op_e ops [9] = '{ex_pkg::op_or, ex_pkg::op_and, ex_pkg::op_xor,
                                     ex_pkg::op_nor, ex_pkg::op_sll, ex_pkg::op_srl,
                                     ex_pkg::op_sra, ex_pkg::op_movn, ex_pkg::op_movz};
        ex_pkg::ex_req_t r;
        repeat (100) begin
            r        = make_req(ops[$urandom_range(0, 8)], pick_val(), pick_val());
            r.reg_we = 1'($urandom_range(0, 1));
            issue(r, 0);
        end
    endtask

    task automatic run_arith();
        ex_pkg::alu_op_e ops [10] = '{ex_pkg::op_addu, ex_pkg::op_subu, ex_pkg::op_slt,
                                      ex_pkg::op_sltu, ex_pkg::op_mul, ex_pkg::op_clz,
                                      ex_pkg::op_clo, ex_pkg::op_jal_link, ex_pkg::op_add,
                                      ex_pkg::op_sub};
        repeat (40) begin
            issue(make_req(ops[$urandom_range(0, 9)], pick_val(), pick_val()), 0);
        end
        issue(make_req(ex_pkg::op_add, 32'h7fff_ffff, 32'h1), 0);   // overflow
        issue(make_req(ex_pkg::op_sub, 32'h8000_0000, 32'h1), 0);   // overflow
        issue(make_req(ex_pkg::op_add, 32'h5, 32'h7), 0);
        issue(make_req(ex_pkg::op_sub, 32'h3, 32'h9), 0);
    endtask

    task automatic run_hilo_direct();
        issue(make_req(ex_pkg::op_mult, pick_val(), pick_val()), 0);
        read_hilo();
        issue(make_req(ex_pkg::op_multu, pick_val(), pick_val()), 0);
        read_hilo();
        issue(make_req(ex_pkg::op_mthi, $urandom, $urandom), 0);
        issue(make_req(ex_pkg::op_mtlo, $urandom, $urandom), 0);
        read_hilo();
    endtask

    task automatic run_madd();
        ex_pkg::alu_op_e ops [4] = '{ex_pkg::op_madd, ex_pkg::op_maddu,
                                     ex_pkg::op_msub, ex_pkg::op_msubu};
        foreach (ops[i]) begin
            issue(make_req(ops[i], pick_val(), pick_val()), 1);
            read_hilo();
        end
    endtask

    task automatic run_div();
        ex_pkg::alu_op_e ops [8] = '{ex_pkg::op_div, ex_pkg::op_div, ex_pkg::op_div,
                                     ex_pkg::op_div, ex_pkg::op_div, ex_pkg::op_divu,
                                     ex_pkg::op_divu, ex_pkg::op_divu};
        logic [31:0] dvd [8] = '{32'd100, -32'sd100, 32'd100, -32'sd100, 32'd77,
                                 32'hffff_ffff, 32'h0, 32'd9};
        logic [31:0] dsr [8] = '{32'd7, 32'd7, -32'sd7, -32'sd7, 32'd0,
                                 32'd3, 32'd0, 32'd0};
        foreach (ops[i]) begin
            issue(make_req(ops[i], dvd[i], dsr[i]), (dsr[i] == '0) ? 1 : DIV_STALL);
            read_hilo();
        end
        issue(make_req(ex_pkg::op_div, $urandom, $urandom | 32'h1), DIV_STALL);
        read_hilo();
        issue(make_req(ex_pkg::op_divu, $urandom, $urandom | 32'h1), DIV_STALL);
        read_hilo();
    endtask

    task automatic run_mem();
        repeat (10) begin
            issue(make_req($urandom_range(0, 1) ? ex_pkg::op_lw : ex_pkg::op_sw,
                           $urandom, pick_val()), 0);
        end
    endtask

    initial begin
        void'($urandom(95003));
        rst_n      = 1'b0;
        ex_req     = '0;
        sh_hi      = '0;
        sh_lo      = '0;
        stall_left = 0;
        cycles     = 0;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        run_single_cycle();
        run_arith();
        run_hilo_direct();
        run_madd();
        run_div();
        run_mem();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/ex_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_top (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire ex_pkg::ex_req_t      ex_req_i,
    output ex_pkg::wb_req_t           wb_o,
    output ex_pkg::mem_req_t          mem_o,
    output logic                      stall_o
);

    logic [`EX_WORD_W-1:0]    logic_res;
    logic [`EX_WORD_W-1:0]    shift_res;
    logic [`EX_WORD_W-1:0]    move_res;
    logic [`EX_WORD_W-1:0]    arith_res;
    logic                     ovf;
    logic [`EX_WORD_W-1:0]    hi;
    logic [`EX_WORD_W-1:0]    lo;
    ex_pkg::acc_state_t       acc_cur;
    ex_pkg::acc_state_t       acc_nxt;
    ex_pkg::hilo_wr_t         hilo_wr;
    logic                     div_start;
    logic                     div_signed;
    logic                     div_ready;
    logic [`EX_DWORD_W-1:0]   div_result;

    ex_alu u_alu (
        .req_i       (ex_req_i),
        .hi_i        (hi),
        .lo_i        (lo),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res),
        .move_res_o  (move_res),
        .arith_res_o (arith_res),
        .ovf_o       (ovf)
    );

    ex_stage u_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (ex_req_i),
        .logic_res_i  (logic_res),
        .shift_res_i  (shift_res),
        .move_res_i   (move_res),
        .arith_res_i  (arith_res),
        .ovf_i        (ovf),
        .hi_i         (hi),
        .lo_i         (lo),
        .acc_i        (acc_cur),
        .div_ready_i  (div_ready),
        .div_result_i (div_result),
        .wb_o         (wb_o),
        .mem_o        (mem_o),
        .hilo_wr_o    (hilo_wr),
        .acc_o        (acc_nxt),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .stall_o      (stall_o)
    );

    div_unit u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (ex_req_i.op1),
        .divisor_i  (ex_req_i.op2),
        .ready_o    (div_ready),
        .result_o   (div_result)
    );

    hilo_unit u_hilo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (hilo_wr),
        .acc_i   (acc_nxt),
        .hi_o    (hi),
        .lo_o    (lo),
        .acc_o   (acc_cur)
    );

endmodule

`default_nettype wire

// ==== verilog/hilo_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module hilo_unit (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire ex_pkg::hilo_wr_t     wr_i,
    input  wire ex_pkg::acc_state_t   acc_i,
    output logic [`EX_WORD_W-1:0]     hi_o,
    output logic [`EX_WORD_W-1:0]     lo_o,
    output ex_pkg::acc_state_t        acc_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_o  <= `EX_HILO_RST;
            lo_o  <= `EX_HILO_RST;
            acc_o <= `EX_ACC_RST;
        end else begin
            if (wr_i.hi_we) begin
                hi_o <= wr_i.hi;
            end
            if (wr_i.lo_we) begin
                lo_o <= wr_i.lo;
            end
            acc_o <= acc_i;                         // stage owns the next state
        end
    end

    // the stage sequence only ever walks 0, 1, 2
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n_i) acc_o.cnt != 2'd3
    );

endmodule

`default_nettype wire

// ==== verilog/div_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module div_unit (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       start_i,
    input  wire                       signed_i,
    input  wire [`EX_WORD_W-1:0]      dividend_i,
    input  wire [`EX_WORD_W-1:0]      divisor_i,
    output logic                      ready_o,
    output logic [`EX_DWORD_W-1:0]    result_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } div_state_e;

    div_state_e                 state_q;
    logic [`EX_DIV_CNT_W-1:0]   cnt_q;
    logic [`EX_WORD_W-1:0]      rem_q;
    logic [`EX_WORD_W-1:0]      quo_q;
    logic [`EX_WORD_W-1:0]      dsr_q;
    logic                       q_neg;
    logic                       r_neg;
    logic [`EX_WORD_W-1:0]      dvd_abs;
    logic [`EX_WORD_W-1:0]      dsr_abs;
    logic [`EX_WORD_W:0]        rem_sh;
    logic                       sub_ok;
    logic [`EX_WORD_W-1:0]      rem_nx;
    logic [`EX_WORD_W-1:0]      quo_nx;
    logic                       last_step;
    logic                       accept;

    assign accept  = (state_q == st_idle) && start_i;
    assign dvd_abs = (signed_i && dividend_i[`EX_WORD_W-1]) ? -dividend_i : dividend_i;
    assign dsr_abs = (signed_i && divisor_i[`EX_WORD_W-1]) ? -divisor_i : divisor_i;

    // one restoring step shifts in the next dividend bit and tries a subtract
    assign rem_sh    = {rem_q, quo_q[`EX_WORD_W-1]};
    assign sub_ok    = rem_sh >= {1'b0, dsr_q};
    assign rem_nx    = sub_ok ? rem_sh[`EX_WORD_W-1:0] - dsr_q : rem_sh[`EX_WORD_W-1:0];
    assign quo_nx    = {quo_q[`EX_WORD_W-2:0], sub_ok};
    assign last_step = cnt_q == `EX_DIV_CNT_W'(`EX_DIV_STEPS - 1);
    assign ready_o   = state_q == st_done;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= (divisor_i == '0) ? st_done : st_busy;
                    end
                end
                st_busy: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= st_done;
                    end
                end
                default: state_q <= st_idle;        // ready for one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rem_q    <= '0;
            quo_q    <= dvd_abs;
            dsr_q    <= dsr_abs;
            q_neg    <= signed_i & (dividend_i[`EX_WORD_W-1] ^ divisor_i[`EX_WORD_W-1]);
            r_neg    <= signed_i & dividend_i[`EX_WORD_W-1];
            result_o <= '0;                         // stays 0 for a zero divisor
        end else if (state_q == st_busy) begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
            if (last_step) begin
                result_o <= {r_neg ? -rem_nx : rem_nx, q_neg ? -quo_nx : quo_nx};
            end
        end
    end

    // one step per busy cycle then a single ready cycle
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        accept && (divisor_i != '0) |-> ##(`EX_DIV_STEPS + 1) ready_o ##1 !ready_o
    );

    a_ready_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        accept && (divisor_i == '0) |=> ready_o ##1 !ready_o
    );

endmodule

`default_nettype wire

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_stage (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire ex_pkg::ex_req_t          req_i,
    input  wire [`EX_WORD_W-1:0]          logic_res_i,
    input  wire [`EX_WORD_W-1:0]          shift_res_i,
    input  wire [`EX_WORD_W-1:0]          move_res_i,
    input  wire [`EX_WORD_W-1:0]          arith_res_i,
    input  wire                           ovf_i,
    input  wire [`EX_WORD_W-1:0]          hi_i,
    input  wire [`EX_WORD_W-1:0]          lo_i,
    input  wire ex_pkg::acc_state_t       acc_i,
    input  wire                           div_ready_i,
    input  wire [`EX_DWORD_W-1:0]         div_result_i,
    output ex_pkg::wb_req_t               wb_o,
    output ex_pkg::mem_req_t              mem_o,
    output ex_pkg::hilo_wr_t              hilo_wr_o,
    output ex_pkg::acc_state_t            acc_o,
    output logic                          div_start_o,
    output logic                          div_signed_o,
    output logic                          stall_o
);

    logic                     is_madd;
    logic                     madd_sgn;
    logic                     madd_sub;
    logic                     is_div;
    logic                     stall_madd;
    logic [`EX_DWORD_W-1:0]   prod_s;
    logic [`EX_DWORD_W-1:0]   prod_u;
    logic [`EX_DWORD_W-1:0]   acc_res;

    assign prod_s   = $signed(req_i.op1) * $signed(req_i.op2);
    assign prod_u   = req_i.op1 * req_i.op2;
    assign is_madd  = req_i.aluop inside {ex_pkg::op_madd, ex_pkg::op_maddu,
                                          ex_pkg::op_msub, ex_pkg::op_msubu};
    assign madd_sgn = req_i.aluop inside {ex_pkg::op_madd, ex_pkg::op_msub};
    assign madd_sub = req_i.aluop inside {ex_pkg::op_msub, ex_pkg::op_msubu};
    assign acc_res  = madd_sub ? {hi_i, lo_i} - acc_i.temp : {hi_i, lo_i} + acc_i.temp;

    // divider runs while the op is held and ready releases it
    assign is_div       = req_i.aluop inside {ex_pkg::op_div, ex_pkg::op_divu};
    assign div_signed_o = req_i.aluop == ex_pkg::op_div;
    assign div_start_o  = is_div & ~div_ready_i;
    assign stall_o      = stall_madd | (is_div & ~div_ready_i);

    always_comb begin
        wb_o.waddr  = req_i.waddr;
        wb_o.reg_we = req_i.reg_we & ~ovf_i;        // overflow drops the write
        case (req_i.alusel)
            ex_pkg::sel_logic: wb_o.res = logic_res_i;
            ex_pkg::sel_shift: wb_o.res = shift_res_i;
            ex_pkg::sel_move:  wb_o.res = move_res_i;
            ex_pkg::sel_arith: wb_o.res = arith_res_i;
            ex_pkg::sel_link:  wb_o.res = req_i.link_addr;
            default:           wb_o.res = '0;
        endcase
    end

    assign mem_o.aluop = req_i.aluop;
    assign mem_o.addr  = req_i.op1 + req_i.op2;
    assign mem_o.wdata = req_i.reg2;

    // madd family takes the product first and accumulates second
    always_comb begin
        acc_o      = '0;
        stall_madd = 1'b0;
        if (is_madd) begin
            case (acc_i.cnt)
                2'd0: begin
                    acc_o.cnt  = 2'd1;
                    acc_o.temp = madd_sgn ? prod_s : prod_u;
                    stall_madd = 1'b1;
                end
                2'd1: begin
                    acc_o.cnt  = 2'd2;
                    acc_o.temp = acc_i.temp;
                end
                default: acc_o = acc_i;                 // done so repeats write nothing
            endcase
        end
    end

    always_comb begin
        hilo_wr_o = '0;
        case (req_i.aluop)
            ex_pkg::op_mthi: begin
                hilo_wr_o.hi_we = 1'b1;
                hilo_wr_o.hi    = req_i.op1;
            end
            ex_pkg::op_mtlo: begin
                hilo_wr_o.lo_we = 1'b1;
                hilo_wr_o.lo    = req_i.op1;
            end
            ex_pkg::op_mult,
            ex_pkg::op_multu: begin
                hilo_wr_o.hi_we = 1'b1;
                hilo_wr_o.lo_we = 1'b1;
                {hilo_wr_o.hi, hilo_wr_o.lo} = div_signed_mux(req_i.aluop == ex_pkg::op_mult);
            end
            ex_pkg::op_madd, ex_pkg::op_maddu,
            ex_pkg::op_msub, ex_pkg::op_msubu: begin
                hilo_wr_o.hi_we = acc_i.cnt == 2'd1;
                hilo_wr_o.lo_we = acc_i.cnt == 2'd1;
                {hilo_wr_o.hi, hilo_wr_o.lo} = acc_res;
            end
            ex_pkg::op_div,
            ex_pkg::op_divu: begin
                hilo_wr_o.hi_we = div_ready_i;
                hilo_wr_o.lo_we = div_ready_i;
                {hilo_wr_o.hi, hilo_wr_o.lo} = div_result_i;   // rem high and quot low
            end
            default: ;
        endcase
    end

    // picks the signed or unsigned full product
    function automatic logic [`EX_DWORD_W-1:0] div_signed_mux(input logic sgn);
        return sgn ? prod_s : prod_u;
    endfunction

    // ready only arrives for a held divide and ends its stall
    a_no_stall_on_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i) div_ready_i |-> is_div && !stall_o
    );

    // a signed add/sub whose result sign flips never commits
    a_ovf_no_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (req_i.alusel == ex_pkg::sel_arith) &&
        (((req_i.aluop == ex_pkg::op_add) &&
          (req_i.op1[`EX_WORD_W-1] == req_i.op2[`EX_WORD_W-1])) ||
         ((req_i.aluop == ex_pkg::op_sub) &&
          (req_i.op1[`EX_WORD_W-1] != req_i.op2[`EX_WORD_W-1]))) &&
        (wb_o.res[`EX_WORD_W-1] != req_i.op1[`EX_WORD_W-1]) |-> !wb_o.reg_we
    );

endmodule

`default_nettype wire

// ==== verilog/ex_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_alu (
    input  wire ex_pkg::ex_req_t      req_i,
    input  wire [`EX_WORD_W-1:0]      hi_i,
    input  wire [`EX_WORD_W-1:0]      lo_i,
    output logic [`EX_WORD_W-1:0]     logic_res_o,
    output logic [`EX_WORD_W-1:0]     shift_res_o,
    output logic [`EX_WORD_W-1:0]     move_res_o,
    output logic [`EX_WORD_W-1:0]     arith_res_o,
    output logic                      ovf_o
);

    logic [4:0]              sh_cnt;
    logic [`EX_WORD_W-1:0]   sum;
    logic [`EX_WORD_W-1:0]   diff;
    logic [`EX_WORD_W-1:0]   mul_lo;
    logic                    a_neg;
    logic                    b_neg;

    // leading run of val scanning from the msb
    function automatic logic [5:0] lead_count(input logic [`EX_WORD_W-1:0] w,
                                              input logic val);
        logic [5:0] n;
        logic       run;
        n   = '0;
        run = 1'b1;
        for (int i = `EX_WORD_W - 1; i >= 0; i--) begin
            if (run && (w[i] == val)) begin
                n = n + 6'd1;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

    assign sh_cnt = req_i.op2[4:0];
    assign sum    = req_i.op1 + req_i.op2;
    assign diff   = req_i.op1 - req_i.op2;
    assign mul_lo = req_i.op1 * req_i.op2;          // low word same for signed
    assign a_neg  = req_i.op1[`EX_WORD_W-1];
    assign b_neg  = req_i.op2[`EX_WORD_W-1];

    // sign of result disagrees with operand signs
    always_comb begin
        case (req_i.aluop)
            ex_pkg::op_add: ovf_o = (~a_neg & ~b_neg & sum[`EX_WORD_W-1]) |
                                    (a_neg & b_neg & ~sum[`EX_WORD_W-1]);
            ex_pkg::op_sub: ovf_o = (~a_neg & b_neg & diff[`EX_WORD_W-1]) |
                                    (a_neg & ~b_neg & ~diff[`EX_WORD_W-1]);
            default:        ovf_o = 1'b0;
        endcase
    end

    always_comb begin
        logic_res_o = '0;
        shift_res_o = '0;
        move_res_o  = '0;
        case (req_i.aluop)
            ex_pkg::op_or:   logic_res_o = req_i.op1 | req_i.op2;
            ex_pkg::op_and:  logic_res_o = req_i.op1 & req_i.op2;
            ex_pkg::op_xor:  logic_res_o = req_i.op1 ^ req_i.op2;
            ex_pkg::op_nor:  logic_res_o = ~(req_i.op1 | req_i.op2);
            ex_pkg::op_sll:  shift_res_o = req_i.op1 << sh_cnt;
            ex_pkg::op_srl:  shift_res_o = req_i.op1 >> sh_cnt;
            ex_pkg::op_sra:  shift_res_o = $signed(req_i.op1) >>> sh_cnt;
            ex_pkg::op_movn,
            ex_pkg::op_movz: move_res_o  = req_i.op1;   // condition sits in reg_we
            ex_pkg::op_mfhi: move_res_o  = hi_i;
            ex_pkg::op_mflo: move_res_o  = lo_i;
            default: ;
        endcase
    end

    always_comb begin
        arith_res_o = '0;
        case (req_i.aluop)
            ex_pkg::op_add,
            ex_pkg::op_addu: arith_res_o = sum;
            ex_pkg::op_sub,
            ex_pkg::op_subu: arith_res_o = diff;
            ex_pkg::op_slt:  arith_res_o = {{(`EX_WORD_W-1){1'b0}},
                                            $signed(req_i.op1) < $signed(req_i.op2)};
            ex_pkg::op_sltu: arith_res_o = {{(`EX_WORD_W-1){1'b0}}, req_i.op1 < req_i.op2};
            ex_pkg::op_mul:  arith_res_o = mul_lo;
            ex_pkg::op_clz:  arith_res_o = {{(`EX_WORD_W-6){1'b0}},
                                            lead_count(req_i.op1, 1'b0)};
            ex_pkg::op_clo:  arith_res_o = {{(`EX_WORD_W-6){1'b0}},
                                            lead_count(req_i.op1, 1'b1)};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ex_pkg.sv ====
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

    typedef enum logic [5:0] {
        op_nop,
        op_or, op_and, op_xor, op_nor,
        op_sll, op_srl, op_sra,
        op_movn, op_movz, op_mfhi, op_mflo, op_mthi, op_mtlo,
        op_add, op_addu, op_sub, op_subu, op_slt, op_sltu,
        op_mul, op_clz, op_clo,
        op_mult, op_multu,
        op_madd, op_maddu, op_msub, op_msubu,
        op_div, op_divu,
        op_jal_link,
        op_lw, op_sw
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_nop,
        sel_logic,
        sel_shift,
        sel_move,
        sel_arith,
        sel_link
    } alu_sel_e;

    typedef struct packed {
        alu_op_e                    aluop;
        alu_sel_e                   alusel;
        logic [`EX_WORD_W-1:0]      op1;
        logic [`EX_WORD_W-1:0]      op2;
        logic [`EX_WORD_W-1:0]      reg2;       // store data
        logic [`EX_REG_ADDR_W-1:0]  waddr;
        logic                       reg_we;
        logic [`EX_WORD_W-1:0]      link_addr;
    } ex_req_t;

    typedef struct packed {
        logic [`EX_REG_ADDR_W-1:0]  waddr;
        logic                       reg_we;
        logic [`EX_WORD_W-1:0]      res;
    } wb_req_t;

    typedef struct packed {
        alu_op_e                    aluop;
        logic [`EX_WORD_W-1:0]      addr;
        logic [`EX_WORD_W-1:0]      wdata;
    } mem_req_t;

    typedef struct packed {
        logic                       hi_we;
        logic                       lo_we;
        logic [`EX_WORD_W-1:0]      hi;
        logic [`EX_WORD_W-1:0]      lo;
    } hilo_wr_t;

    typedef struct packed {
        logic [1:0]                 cnt;        // madd cycle
        logic [`EX_DWORD_W-1:0]     temp;       // saved product
    } acc_state_t;

endpackage

`default_nettype wire

// ==== verilog/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// datapath widths
`define EX_WORD_W       32
`define EX_DWORD_W      (2 * `EX_WORD_W)
`define EX_REG_ADDR_W   5

// divider sequencing
`define EX_DIV_STEPS    32
`define EX_DIV_CNT_W    6

// reset values
`define EX_HILO_RST     {`EX_WORD_W{1'b0}}
`define EX_ACC_RST      {2'b00, {`EX_DWORD_W{1'b0}}}

`endif
